// File: design/axi_pkg.sv
// single-beat AXI4 only: 64-bit data, 32-bit address, no IDs, no user signals
package axi_pkg;

  // ------------------------------------------------------------------
  // bus widths
  // ------------------------------------------------------------------
  localparam int AXI_DATA_W = 64;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;  // one strobe per byte lane

  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [7:0]            axi_len_t;   // beats minus one
  typedef logic [2:0]            axi_size_t;  // log2 of bytes per beat
  typedef logic [1:0]            axi_burst_t;
  typedef logic [2:0]            axi_prot_t;
  typedef logic [3:0]            axi_cache_t;
  typedef logic [1:0]            axi_resp_t;

  // ------------------------------------------------------------------
  // fixed attribute and response codes
  // ------------------------------------------------------------------
  localparam axi_burst_t BURST_INCR              = 2'b01;
  localparam axi_prot_t  PROT_DATA_SECURE_UNPRIV = 3'b000;
  localparam axi_cache_t CACHE_DEVICE_NONBUF     = 4'b0000;
  localparam axi_resp_t  RESP_OKAY               = 2'b00;
  localparam axi_resp_t  RESP_SLVERR             = 2'b10;

endpackage

// File: design/core_bus_pkg.sv
// core-side request types; SRAM depth is fixed here and must match SRAM_IDX_W
package core_bus_pkg;

  // access size, same encoding as the low two bits of AXI size
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'd0,
    SIZE_HALF  = 2'd1,
    SIZE_WORD  = 2'd2,
    SIZE_DWORD = 2'd3
  } access_size_e;

  // which core port issued a request
  typedef enum logic {
    OWNER_IF  = 1'b0,
    OWNER_MEM = 1'b1
  } req_owner_e;

  localparam int SRAM_WORDS = 1024;  // 64-bit words, 8 KiB
  localparam int SRAM_IDX_W = 10;    // log2(SRAM_WORDS)

  typedef logic [SRAM_IDX_W-1:0] sram_idx_t;

endpackage

// File: design/core_req_if.sv
// request is held until addr_ok; rdata and err are only valid with data_ok
`timescale 1ns/1ps

interface core_req_if;
  import axi_pkg::*;
  import core_bus_pkg::*;

  // requester to server
  logic         req;
  logic         wr;      // 1 for write
  access_size_e size;
  axi_addr_t    addr;
  axi_strb_t    wstrb;
  axi_data_t    wdata;

  // server to requester
  logic         addr_ok; // request taken
  logic         data_ok; // request finished
  axi_data_t    rdata;
  logic         err;     // slave error on this access

  modport master (
    output req, wr, size, addr, wstrb, wdata,
    input  addr_ok, data_ok, rdata, err
  );

  modport slave (
    input  req, wr, size, addr, wstrb, wdata,
    output addr_ok, data_ok, rdata, err
  );

endinterface

// File: design/axi4_if.sv
// AXI4 without ID and user signals; lock is the single AXI4 bit
`timescale 1ns/1ps

interface axi4_if;
  import axi_pkg::*;

  // write address
  axi_addr_t  awaddr;
  axi_len_t   awlen;
  axi_size_t  awsize;
  axi_burst_t awburst;
  logic       awlock;
  axi_cache_t awcache;
  axi_prot_t  awprot;
  logic       awvalid;
  logic       awready;

  // write data
  axi_data_t  wdata;
  axi_strb_t  wstrb;
  logic       wlast;
  logic       wvalid;
  logic       wready;

  // write response
  axi_resp_t  bresp;
  logic       bvalid;
  logic       bready;

  // read address
  axi_addr_t  araddr;
  axi_len_t   arlen;
  axi_size_t  arsize;
  axi_burst_t arburst;
  logic       arlock;
  axi_cache_t arcache;
  axi_prot_t  arprot;
  logic       arvalid;
  logic       arready;

  // read data
  axi_data_t  rdata;
  axi_resp_t  rresp;
  logic       rlast;
  logic       rvalid;
  logic       rready;

  modport master (
    output awaddr, awlen, awsize, awburst, awlock, awcache, awprot, awvalid,
    input  awready,
    output wdata, wstrb, wlast, wvalid,
    input  wready,
    input  bresp, bvalid,
    output bready,
    output araddr, arlen, arsize, arburst, arlock, arcache, arprot, arvalid,
    input  arready,
    input  rdata, rresp, rlast, rvalid,
    output rready
  );

  modport slave (
    input  awaddr, awlen, awsize, awburst, awlock, awcache, awprot, awvalid,
    output awready,
    input  wdata, wstrb, wlast, wvalid,
    output wready,
    output bresp, bvalid,
    input  bready,
    input  araddr, arlen, arsize, arburst, arlock, arcache, arprot, arvalid,
    output arready,
    output rdata, rresp, rlast, rvalid,
    input  rready
  );

endinterface

// File: design/core_port_arbiter.sv
// MEM beats IF; one read in flight; responses return in the order they were accepted
`timescale 1ns/1ps

module core_port_arbiter (
  input  logic                       i_aclk,
  input  logic                       i_rst_n,
  // instruction fetch, read only
  input  logic                       i_if_req,
  input  axi_pkg::axi_addr_t         i_if_addr,
  input  core_bus_pkg::access_size_e i_if_size,
  output logic                       o_if_addr_ok,
  output logic                       o_if_data_ok,
  output axi_pkg::axi_data_t         o_if_rdata,
  output logic                       o_if_err,
  // data memory
  input  logic                       i_mem_req,
  input  logic                       i_mem_wr,
  input  core_bus_pkg::access_size_e i_mem_size,
  input  axi_pkg::axi_addr_t         i_mem_addr,
  input  axi_pkg::axi_strb_t         i_mem_wstrb,
  input  axi_pkg::axi_data_t         i_mem_wdata,
  output logic                       o_mem_addr_ok,
  output logic                       o_mem_data_ok,
  output axi_pkg::axi_data_t         o_mem_rdata,
  output logic                       o_mem_err,
  core_req_if.master                 bus
);
  import core_bus_pkg::*;

  logic       hold_q;       // forwarded request still waiting for addr_ok
  req_owner_e hold_owner_q;
  logic       rd_busy_q;
  logic       wr_busy_q;
  logic       last_wr_q;    // newest accepted request was a write
  req_owner_e rd_owner_q;
  req_owner_e grant;
  logic       mem_can;
  logic       if_can;
  logic       rd_acc;
  logic       wr_acc;
  logic       resp_rd;
  logic       rd_done;

  // ------------------------------------------------------------------
  // grant
  // ------------------------------------------------------------------
  assign mem_can = i_mem_req && (i_mem_wr || !rd_busy_q);  // writes never wait on reads
  assign if_can  = i_if_req && !rd_busy_q;

  always_comb begin
    if (hold_q) begin
      grant = hold_owner_q;  // keep the request stable until taken
    end else if (mem_can) begin
      grant = OWNER_MEM;
    end else begin
      grant = OWNER_IF;
    end
  end

  always_comb begin
    if (grant == OWNER_MEM) begin
      bus.req  = mem_can;
      bus.wr   = i_mem_wr;
      bus.size = i_mem_size;
      bus.addr = i_mem_addr;
    end else begin
      bus.req  = if_can;
      bus.wr   = 1'b0;
      bus.size = i_if_size;
      bus.addr = i_if_addr;
    end
  end

  assign bus.wstrb = i_mem_wstrb;  // only IF reads pass through otherwise
  assign bus.wdata = i_mem_wdata;

  assign o_if_addr_ok  = bus.addr_ok && (grant == OWNER_IF);
  assign o_mem_addr_ok = bus.addr_ok && (grant == OWNER_MEM);

  // ------------------------------------------------------------------
  // outstanding tracking and response routing
  // ------------------------------------------------------------------
  assign rd_acc  = bus.addr_ok && !bus.wr;
  assign wr_acc  = bus.addr_ok && bus.wr;
  assign resp_rd = rd_busy_q && (!wr_busy_q || last_wr_q);  // older one answers first
  assign rd_done = bus.data_ok && resp_rd;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hold_q       <= 1'b0;
      hold_owner_q <= OWNER_IF;
      rd_busy_q    <= 1'b0;
      wr_busy_q    <= 1'b0;
      last_wr_q    <= 1'b0;
      rd_owner_q   <= OWNER_IF;
    end else begin
      hold_q       <= bus.req && !bus.addr_ok;
      hold_owner_q <= grant;
      if (rd_acc) begin
        rd_busy_q  <= 1'b1;
        rd_owner_q <= grant;
        last_wr_q  <= 1'b0;
      end else if (rd_done) begin
        rd_busy_q  <= 1'b0;
      end
      if (wr_acc) begin
        wr_busy_q <= 1'b1;
        last_wr_q <= 1'b1;
      end else if (bus.data_ok && !resp_rd) begin
        wr_busy_q <= 1'b0;
      end
    end
  end

  assign o_if_data_ok  = rd_done && (rd_owner_q == OWNER_IF);
  assign o_mem_data_ok = bus.data_ok && !o_if_data_ok;  // every write ends on MEM
  assign o_if_rdata    = bus.rdata;
  assign o_mem_rdata   = bus.rdata;
  assign o_if_err      = bus.err;
  assign o_mem_err     = bus.err;

endmodule

// File: design/axi4_master_bridge.sv
// one read and one write in flight; their data_ok pulses come back in accept order
`timescale 1ns/1ps

module axi4_master_bridge (
  input  logic      i_aclk,
  input  logic      i_rst_n,
  core_req_if.slave core,
  axi4_if.master    axi
);
  import axi_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_SEND,
    WR_RESP
  } wr_state_e;

  rd_state_e rd_state_q;
  wr_state_e wr_state_q;
  logic      aw_done_q;   // AW taken while W still waits
  logic      w_done_q;
  logic      last_wr_q;   // newest accepted was a write
  logic      ar_fire;
  logic      r_fire;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;
  logic      wr_accept;
  logic      data_ok_q;
  logic      err_q;
  axi_data_t rdata_q;

  assign ar_fire   = axi.arvalid && axi.arready;
  assign r_fire    = axi.rvalid && axi.rready;
  assign aw_fire   = axi.awvalid && axi.awready;
  assign w_fire    = axi.wvalid && axi.wready;
  assign b_fire    = axi.bvalid && axi.bready;
  assign wr_accept = (wr_state_q == WR_SEND) && (aw_done_q || aw_fire) && (w_done_q || w_fire);

  // ------------------------------------------------------------------
  // read FSM
  // ------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_state_q <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: if (core.req && !core.wr) rd_state_q <= RD_ADDR;
        RD_ADDR: if (ar_fire) rd_state_q <= RD_DATA;
        RD_DATA: if (r_fire) rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // write FSM
  // ------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_state_q <= WR_IDLE;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (core.req && core.wr) wr_state_q <= WR_SEND;
        WR_SEND: if (wr_accept) wr_state_q <= WR_RESP;
        WR_RESP: if (b_fire) wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
      if (wr_accept || wr_state_q != WR_SEND) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        aw_done_q <= aw_done_q || aw_fire;
        w_done_q  <= w_done_q || w_fire;
      end
    end
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      last_wr_q <= 1'b0;
    end else if (wr_accept) begin
      last_wr_q <= 1'b1;
    end else if (ar_fire) begin
      last_wr_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------------
  // AXI channels
  // ------------------------------------------------------------------
  assign axi.awaddr  = core.addr;
  assign axi.awlen   = axi_len_t'(0);  // single beat
  assign axi.awsize  = {1'b0, core.size};
  assign axi.awburst = BURST_INCR;
  assign axi.awlock  = 1'b0;
  assign axi.awcache = CACHE_DEVICE_NONBUF;
  assign axi.awprot  = PROT_DATA_SECURE_UNPRIV;
  assign axi.awvalid = (wr_state_q == WR_SEND) && !aw_done_q;

  assign axi.wdata  = core.wdata;
  assign axi.wstrb  = core.wstrb;
  assign axi.wlast  = 1'b1;
  assign axi.wvalid = (wr_state_q == WR_SEND) && !w_done_q;

  assign axi.araddr  = core.addr;
  assign axi.arlen   = axi_len_t'(0);
  assign axi.arsize  = {1'b0, core.size};
  assign axi.arburst = BURST_INCR;
  assign axi.arlock  = 1'b0;
  assign axi.arcache = CACHE_DEVICE_NONBUF;
  assign axi.arprot  = PROT_DATA_SECURE_UNPRIV;
  assign axi.arvalid = (rd_state_q == RD_ADDR);

  // the younger response waits so data_ok order matches addr_ok order
  assign axi.rready = (rd_state_q == RD_DATA) && (wr_state_q != WR_RESP || last_wr_q);
  assign axi.bready = (wr_state_q == WR_RESP) && (rd_state_q != RD_DATA || !last_wr_q);

  // ------------------------------------------------------------------
  // core responses
  // ------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_ok_q <= 1'b0;
    end else begin
      data_ok_q <= r_fire || b_fire;  // never both, see ready gating
    end
  end

  always_ff @(posedge i_aclk) begin
    if (r_fire) begin
      rdata_q <= axi.rdata;
      err_q   <= (axi.rresp != RESP_OKAY);
    end else if (b_fire) begin
      err_q   <= (axi.bresp != RESP_OKAY);
    end
  end

  assign core.addr_ok = ar_fire || wr_accept;
  assign core.data_ok = data_ok_q;
  assign core.rdata   = rdata_q;
  assign core.err     = err_q;

endmodule

// File: design/axi4_sram_slave.sv
// whole 64-bit words only, size is ignored; out-of-range accesses get SLVERR
`timescale 1ns/1ps

module axi4_sram_slave (
  input  logic   i_aclk,
  input  logic   i_rst_n,
  axi4_if.slave  axi
);
  import axi_pkg::*;
  import core_bus_pkg::*;

  axi_data_t mem [SRAM_WORDS];
  logic      rvalid_q;
  logic      bvalid_q;
  axi_data_t rdata_q;
  axi_resp_t rresp_q;
  axi_resp_t bresp_q;
  logic      ar_fire;
  logic      wr_take;   // AW and W together
  logic      ar_hit;
  logic      aw_hit;
  sram_idx_t ar_idx;
  sram_idx_t aw_idx;

  // word index is the address above the byte lanes
  function automatic logic addr_hit(axi_addr_t addr);
    return (addr >> $clog2(AXI_STRB_W)) < axi_addr_t'(SRAM_WORDS);
  endfunction

  assign ar_idx = axi.araddr[$clog2(AXI_STRB_W) +: SRAM_IDX_W];
  assign aw_idx = axi.awaddr[$clog2(AXI_STRB_W) +: SRAM_IDX_W];
  assign ar_hit = addr_hit(axi.araddr);
  assign aw_hit = addr_hit(axi.awaddr);

  assign axi.arready = !rvalid_q;                                   // one read pending
  assign wr_take     = !bvalid_q && axi.awvalid && axi.wvalid;
  assign axi.awready = wr_take;
  assign axi.wready  = wr_take;
  assign ar_fire     = axi.arvalid && !rvalid_q;

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (wr_take && aw_hit) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (axi.wstrb[b]) begin
          mem[aw_idx][8*b +: 8] <= axi.wdata[8*b +: 8];  // byte lane merge
        end
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rdata_q <= ar_hit ? mem[ar_idx] : '0;
      rresp_q <= ar_hit ? RESP_OKAY : RESP_SLVERR;
    end
    if (wr_take) begin
      bresp_q <= aw_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ------------------------------------------------------------------
  // response handshakes
  // ------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        rvalid_q <= 1'b1;
      end else if (axi.rready) begin
        rvalid_q <= 1'b0;  // held until the master takes it
      end
      if (wr_take) begin
        bvalid_q <= 1'b1;
      end else if (axi.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  assign axi.rvalid = rvalid_q;
  assign axi.rdata  = rdata_q;
  assign axi.rresp  = rresp_q;
  assign axi.rlast  = 1'b1;
  assign axi.bvalid = bvalid_q;
  assign axi.bresp  = bresp_q;

endmodule

// File: design/mem_subsys_top.sv
// latency depends on contention; use data_ok to end a transaction, not a cycle count
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                       i_aclk,
  input  logic                       i_rst_n,
  // instruction fetch port
  input  logic                       i_if_req,
  input  axi_pkg::axi_addr_t         i_if_addr,
  input  core_bus_pkg::access_size_e i_if_size,
  output logic                       o_if_addr_ok,
  output logic                       o_if_data_ok,
  output axi_pkg::axi_data_t         o_if_rdata,
  output logic                       o_if_err,
  // data memory port
  input  logic                       i_mem_req,
  input  logic                       i_mem_wr,
  input  core_bus_pkg::access_size_e i_mem_size,
  input  axi_pkg::axi_addr_t         i_mem_addr,
  input  axi_pkg::axi_strb_t         i_mem_wstrb,
  input  axi_pkg::axi_data_t         i_mem_wdata,
  output logic                       o_mem_addr_ok,
  output logic                       o_mem_data_ok,
  output axi_pkg::axi_data_t         o_mem_rdata,
  output logic                       o_mem_err
);

  core_req_if core_bus ();  // arbiter to bridge
  axi4_if     axi_bus ();   // bridge to SRAM

  core_port_arbiter u_arbiter (
    .i_aclk, .i_rst_n,
    .i_if_req, .i_if_addr, .i_if_size,
    .o_if_addr_ok, .o_if_data_ok, .o_if_rdata, .o_if_err,
    .i_mem_req, .i_mem_wr, .i_mem_size, .i_mem_addr, .i_mem_wstrb, .i_mem_wdata,
    .o_mem_addr_ok, .o_mem_data_ok, .o_mem_rdata, .o_mem_err,
    .bus (core_bus)
  );

  axi4_master_bridge u_bridge (
    .i_aclk,
    .i_rst_n,
    .core (core_bus),
    .axi  (axi_bus)
  );

  axi4_sram_slave u_sram (
    .i_aclk,
    .i_rst_n,
    .axi (axi_bus)
  );

endmodule

// File: sim/mem_subsys_checker.sv
// protocol checks only; needs the axi_bus instance name inside mem_subsys_top
`timescale 1ns/1ps

module mem_subsys_checker (
  input logic                   i_aclk,
  input logic                   i_rst_n,
  input logic                   i_if_addr_ok,
  input logic                   i_if_data_ok,
  input logic                   i_mem_addr_ok,
  input logic                   i_mem_data_ok,
  input logic                   i_awvalid,
  input logic                   i_awready,
  input axi_pkg::axi_addr_t     i_awaddr,
  input axi_pkg::axi_len_t      i_awlen,
  input axi_pkg::axi_burst_t    i_awburst,
  input logic                   i_wvalid,
  input logic                   i_wready,
  input axi_pkg::axi_data_t     i_wdata,
  input axi_pkg::axi_strb_t     i_wstrb,
  input logic                   i_wlast,
  input logic                   i_bvalid,
  input logic                   i_bready,
  input axi_pkg::axi_resp_t     i_bresp,
  input logic                   i_arvalid,
  input logic                   i_arready,
  input axi_pkg::axi_addr_t     i_araddr,
  input axi_pkg::axi_len_t      i_arlen,
  input axi_pkg::axi_burst_t    i_arburst,
  input logic                   i_rvalid,
  input logic                   i_rready,
  input axi_pkg::axi_data_t     i_rdata,
  input axi_pkg::axi_resp_t     i_rresp
);
  import axi_pkg::*;

  logic [1:0] if_open_q;   // accepted but not yet answered
  logic [1:0] mem_open_q;  // MEM may hold one read and one write
  int         fail_count = 0;  // failed assertions so far

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      if_open_q  <= '0;
      mem_open_q <= '0;
    end else begin
      if_open_q  <= if_open_q + 2'(i_if_addr_ok) - 2'(i_if_data_ok);
      mem_open_q <= mem_open_q + 2'(i_mem_addr_ok) - 2'(i_mem_data_ok);
    end
  end

  // ------------------------------------------------------------------
  // core side pairing
  // ------------------------------------------------------------------
  a_if_paired: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_if_data_ok |-> if_open_q != 0) else begin
    $error("IF data_ok without open addr_ok");
    fail_count++;
  end
  a_mem_paired: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_mem_data_ok |-> mem_open_q != 0) else begin
    $error("MEM data_ok without open addr_ok");
    fail_count++;
  end

  // ------------------------------------------------------------------
  // valid held with stable payload until ready
  // ------------------------------------------------------------------
  a_aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr)) else begin
    $error("AW dropped");
    fail_count++;
  end
  a_w_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb))
    else begin
    $error("W dropped");
    fail_count++;
  end
  a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp)) else begin
    $error("B dropped");
    fail_count++;
  end
  a_ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr)) else begin
    $error("AR dropped");
    fail_count++;
  end
  a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
    else begin
    $error("R dropped");
    fail_count++;
  end

  // single beat INCR only
  a_aw_beat: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid |-> i_awlen == 0 && i_awburst == BURST_INCR) else begin
    $error("bad AW burst");
    fail_count++;
  end
  a_w_last: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_wvalid |-> i_wlast) else begin
    $error("wlast low on single beat");
    fail_count++;
  end
  a_ar_beat: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_arvalid |-> i_arlen == 0 && i_arburst == BURST_INCR) else begin
    $error("bad AR burst");
    fail_count++;
  end

  // quiet in reset and the first cycle out of it
  a_reset_quiet: assert property (@(posedge i_aclk)
    (!i_rst_n || $rose(i_rst_n)) |->
      !(i_awvalid || i_wvalid || i_bvalid || i_arvalid || i_rvalid || i_bready || i_rready ||
        i_if_addr_ok || i_if_data_ok || i_mem_addr_ok || i_mem_data_ok))
    else begin
    $error("handshake active around reset");
    fail_count++;
  end

endmodule

bind mem_subsys_top mem_subsys_checker u_checker (
  .i_aclk        (i_aclk),
  .i_rst_n       (i_rst_n),
  .i_if_addr_ok  (o_if_addr_ok),
  .i_if_data_ok  (o_if_data_ok),
  .i_mem_addr_ok (o_mem_addr_ok),
  .i_mem_data_ok (o_mem_data_ok),
  .i_awvalid     (axi_bus.awvalid),
  .i_awready     (axi_bus.awready),
  .i_awaddr      (axi_bus.awaddr),
  .i_awlen       (axi_bus.awlen),
  .i_awburst     (axi_bus.awburst),
  .i_wvalid      (axi_bus.wvalid),
  .i_wready      (axi_bus.wready),
  .i_wdata       (axi_bus.wdata),
  .i_wstrb       (axi_bus.wstrb),
  .i_wlast       (axi_bus.wlast),
  .i_bvalid      (axi_bus.bvalid),
  .i_bready      (axi_bus.bready),
  .i_bresp       (axi_bus.bresp),
  .i_arvalid     (axi_bus.arvalid),
  .i_arready     (axi_bus.arready),
  .i_araddr      (axi_bus.araddr),
  .i_arlen       (axi_bus.arlen),
  .i_arburst     (axi_bus.arburst),
  .i_rvalid      (axi_bus.rvalid),
  .i_rready      (axi_bus.rready),
  .i_rdata       (axi_bus.rdata),
  .i_rresp       (axi_bus.rresp)
);

// File: sim/mem_subsys_tb.sv
// random traffic stays in words 0..31, which are filled first; expected values fixed at addr_ok
`timescale 1ns/1ps

module mem_subsys_tb;
  import axi_pkg::*;
  import core_bus_pkg::*;

  localparam int MAX_CYCLES = 4000;  // ~150 transactions at <= 20 cycles, with margin
  localparam int FILL_WORDS = 32;

  typedef struct packed {
    logic      rd;
    axi_data_t data;
    logic      err;
  } expect_t;

  logic i_aclk = 1'b0;
  logic i_rst_n;
  logic i_if_req, i_mem_req, i_mem_wr;
  axi_addr_t i_if_addr, i_mem_addr;
  access_size_e i_if_size, i_mem_size;
  axi_strb_t i_mem_wstrb;
  axi_data_t i_mem_wdata;
  logic o_if_addr_ok, o_if_data_ok, o_if_err, o_mem_addr_ok, o_mem_data_ok, o_mem_err;
  axi_data_t o_if_rdata, o_mem_rdata;

  axi_data_t ref_mem [SRAM_WORDS];
  expect_t   if_q[$];
  expect_t   mem_q[$];
  logic      if_head_valid = 1'b0;
  logic      mem_head_valid = 1'b0;
  expect_t   if_head;
  expect_t   mem_head;
  int        errors = 0;
  int        cycles = 0;
  int        if_ok_cycle;
  int        mem_ok_cycle;
  integer    seed = 89;

  mem_subsys_top uut (.*);

  always #4 i_aclk = ~i_aclk;

  always @(posedge i_aclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out waiting for responses after %0d cycles", cycles);
      $display("errors: %0d", errors + uut.u_checker.fail_count + 1);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic in_range(axi_addr_t addr);
    return (addr >> 3) < SRAM_WORDS;
  endfunction

  function automatic axi_data_t merge_bytes(axi_data_t old, axi_data_t data, axi_strb_t strb);
    axi_data_t res;
    res = old;
    for (int b = 0; b < AXI_STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // ------------------------------------------------------------------
  // reference model, updated at addr_ok
  // ------------------------------------------------------------------
  always @(posedge i_aclk) begin : track
    logic      hit;
    axi_data_t word;
    if (i_rst_n) begin
      if (o_mem_data_ok && mem_q.size() != 0) void'(mem_q.pop_front());
      if (o_if_data_ok && if_q.size() != 0) void'(if_q.pop_front());
      if (o_mem_addr_ok) begin
        hit  = in_range(i_mem_addr);
        word = hit ? ref_mem[i_mem_addr[3 +: SRAM_IDX_W]] : '0;
        if (i_mem_wr) begin
          if (hit) ref_mem[i_mem_addr[3 +: SRAM_IDX_W]] = merge_bytes(word, i_mem_wdata,
                                                                      i_mem_wstrb);
          mem_q.push_back('{1'b0, '0, !hit});
        end else begin
          mem_q.push_back('{1'b1, word, !hit});
        end
      end
      if (o_if_addr_ok) begin
        hit = in_range(i_if_addr);
        if_q.push_back('{1'b1, hit ? ref_mem[i_if_addr[3 +: SRAM_IDX_W]] : '0, !hit});
      end
      mem_head_valid = mem_q.size() != 0;  // heads are sampled by the assertions
      if_head_valid  = if_q.size() != 0;
      if (mem_head_valid) mem_head = mem_q[0];
      if (if_head_valid) if_head = if_q[0];
    end
  end

  // ------------------------------------------------------------------
  // response checks
  // ------------------------------------------------------------------
  a_mem_owned: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_mem_data_ok |-> mem_head_valid) else begin
    $display("MEM data_ok arrived with no MEM request outstanding");
    errors++;
  end
  a_mem_rdata: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_mem_data_ok && mem_head_valid && mem_head.rd |-> o_mem_rdata == mem_head.data) else begin
    $display("MISMATCH o_mem_rdata exp %h got %h", $sampled(mem_head.data), $sampled(o_mem_rdata));
    errors++;
  end
  a_mem_err: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_mem_data_ok && mem_head_valid |-> o_mem_err == mem_head.err) else begin
    $display("MISMATCH o_mem_err exp %h got %h", $sampled(mem_head.err), $sampled(o_mem_err));
    errors++;
  end
  a_if_owned: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_if_data_ok |-> if_head_valid) else begin
    $display("IF data_ok arrived with no IF request outstanding");
    errors++;
  end
  a_if_rdata: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_if_data_ok && if_head_valid |-> o_if_rdata == if_head.data) else begin
    $display("MISMATCH o_if_rdata exp %h got %h", $sampled(if_head.data), $sampled(o_if_rdata));
    errors++;
  end
  a_if_err: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_if_data_ok && if_head_valid |-> o_if_err == if_head.err) else begin
    $display("MISMATCH o_if_err exp %h got %h", $sampled(if_head.err), $sampled(o_if_err));
    errors++;
  end

  // ------------------------------------------------------------------
  // port drivers, entered 1 ns after an edge
  // ------------------------------------------------------------------
  task automatic mem_access(logic wr, access_size_e size, axi_addr_t addr, axi_strb_t strb,
                            axi_data_t data);
    i_mem_req   = 1'b1;
    i_mem_wr    = wr;
    i_mem_size  = size;
    i_mem_addr  = addr;
    i_mem_wstrb = strb;
    i_mem_wdata = data;
    do @(posedge i_aclk); while (!o_mem_addr_ok);
    #1 i_mem_req = 1'b0;
    mem_ok_cycle = cycles;
  endtask

  task automatic if_read(axi_addr_t addr);
    i_if_req  = 1'b1;
    i_if_addr = addr;
    i_if_size = SIZE_DWORD;
    do @(posedge i_aclk); while (!o_if_addr_ok);
    #1 i_if_req = 1'b0;
    if_ok_cycle = cycles;
  endtask

  task automatic wait_idle();
    while (if_q.size() != 0 || mem_q.size() != 0) @(posedge i_aclk);
    @(posedge i_aclk);
    #1;
  endtask

  task automatic random_if_reads(int n);
    for (int k = 0; k < n; k++) if_read(axi_addr_t'(($random(seed) & 31) << 3));
  endtask

  task automatic random_mem_traffic(int n);
    logic [31:0] r;
    for (int k = 0; k < n; k++) begin
      r = $random(seed);
      mem_access(r[0], access_size_e'(r[2:1]), axi_addr_t'({r[12:8], 3'b000}), r[23:16],
                 {$random(seed), $random(seed)});
    end
  endtask

  initial begin
    i_rst_n = 1'b1;
    i_if_req = 1'b0;
    i_if_addr = '0;
    i_if_size = SIZE_DWORD;
    i_mem_req = 1'b0;
    i_mem_wr = 1'b0;
    i_mem_size = SIZE_DWORD;
    i_mem_addr = '0;
    i_mem_wstrb = '0;
    i_mem_wdata = '0;
    #1 i_rst_n = 1'b0;
    repeat (4) @(posedge i_aclk);
    #1 i_rst_n = 1'b1;

    for (int i = 0; i < FILL_WORDS; i++) begin  // pattern from the whole address
      mem_access(1'b1, SIZE_DWORD, axi_addr_t'(i << 3), 8'hff, {32'(i << 3), ~32'(i << 3)});
    end
    // full write and read back
    mem_access(1'b1, SIZE_DWORD, 32'h320, 8'hff, 64'h0123_4567_89ab_cdef);
    mem_access(1'b0, SIZE_DWORD, 32'h320, '0, '0);
    // byte, half and word lanes merged into a known word
    mem_access(1'b1, SIZE_DWORD, 32'h328, 8'hff, 64'h1111_2222_3333_4444);
    mem_access(1'b1, SIZE_BYTE, 32'h32e, 8'h40, 64'h00aa_0000_0000_0000);
    mem_access(1'b1, SIZE_HALF, 32'h32c, 8'h30, 64'h0000_bbcc_0000_0000);
    mem_access(1'b1, SIZE_WORD, 32'h328, 8'h0f, 64'hffff_ffff_dead_beef);
    mem_access(1'b0, SIZE_DWORD, 32'h328, '0, '0);
    wait_idle();
    // same cycle requests, MEM wins
    mem_access(1'b1, SIZE_DWORD, 32'h330, 8'hff, 64'hfeed_0000_face_0001);
    fork
      mem_access(1'b0, SIZE_DWORD, 32'h320, '0, '0);
      if_read(32'h330);
    join
    a_mem_first: assert (mem_ok_cycle < if_ok_cycle) else begin
      $display("IF was granted before MEM on simultaneous requests");
      errors++;
    end
    if_read(32'h320);
    if_read(32'h328);
    wait_idle();
    // word index 1024 aliases word 0 in the low bits
    mem_access(1'b1, SIZE_DWORD, 32'h2000, 8'hff, 64'hbad0_bad0_bad0_bad0);
    mem_access(1'b0, SIZE_DWORD, 32'h2000, '0, '0);
    if_read(32'h2008);
    mem_access(1'b0, SIZE_DWORD, 32'h0, '0, '0);
    wait_idle();
    fork
      random_if_reads(40);
      random_mem_traffic(60);
    join
    wait_idle();

    errors = errors + uut.u_checker.fail_count;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: mem_subsys.f
design/axi_pkg.sv
design/core_bus_pkg.sv
design/core_req_if.sv
design/axi4_if.sv
design/core_port_arbiter.sv
design/axi4_master_bridge.sv
design/axi4_sram_slave.sv
design/mem_subsys_top.sv
sim/mem_subsys_checker.sv
sim/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - design/axi_pkg.sv
  - design/core_bus_pkg.sv
  - design/core_req_if.sv
  - design/axi4_if.sv
  - design/core_port_arbiter.sv
  - design/axi4_master_bridge.sv
  - design/axi4_sram_slave.sv
  - design/mem_subsys_top.sv
  - target: simulation
    files:
      - sim/mem_subsys_checker.sv
      - sim/mem_subsys_tb.sv
